//--- Bender.yml
package:
  name: usb_dfu_ctrl_ep

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - usb_dfu_pkg.sv
      - ctrl_req_if.sv
      - usb_setup_decoder.sv
      - usb_ctrl_sequencer.sv
      - usb_desc_source.sv
      - usb_dfu_ctrl_ep.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_usb_dfu_ctrl_ep.sv

//--- ctrl_req_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_dfu_settings.svh"

// decoded setup request, valid while the setup bytes are held
interface ctrl_req_if;

  logic                        dir_in;     // device to host
  logic                        has_data;   // wLength != 0
  usb_dfu_pkg::word_t          wlength;
  usb_dfu_pkg::data_src_e      src;
  logic [`DESC_ADDR_WIDTH-1:0] src_addr;
  usb_dfu_pkg::word_t          src_len;
  logic                        stall_req;
  logic                        set_addr;
  logic [6:0]                  new_addr;

  modport decoder (
    output dir_in, has_data, wlength,
    output src, src_addr, src_len,
    output stall_req, set_addr, new_addr
  );

  modport consumer (
    input dir_in, has_data, wlength,
    input src, src_addr, src_len,
    input stall_req, set_addr, new_addr
  );

endinterface

`default_nettype wire

//--- tb_usb_dfu_ctrl_ep.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_dfu_settings.svh"

module tb_usb_dfu_ctrl_ep;

  localparam usb_dfu_pkg::word_t vid = `USB_VENDOR_ID;
  localparam usb_dfu_pkg::word_t pid = `USB_PRODUCT_ID;
  localparam usb_dfu_pkg::word_t xfer = `DFU_TRANSFER_SIZE;
  localparam int wait_limit = 2000;

  // device 0..17, configuration set 18..44, language string 45..48
  localparam usb_dfu_pkg::byte_t desc_model [49] = '{
    8'd18, 8'h01, 8'h00, 8'h01, 8'h00, 8'h00, 8'h00, `USB_MAX_PACKET_SIZE,
    vid[7:0], vid[15:8], pid[7:0], pid[15:8], 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h01,
    8'd9, 8'h02, 8'd27, 8'h00, 8'h01, 8'h01, 8'h00, 8'hc0, 8'd50,
    8'd9, 8'h04, 8'h00, 8'h00, 8'h00, 8'hfe, 8'h01, 8'h02, 8'h00,
    8'd9, 8'h21, 8'h0b, 8'hff, 8'h00, xfer[7:0], xfer[15:8], 8'h1a, 8'h01,
    8'd4, 8'h03, 8'h09, 8'h04
  };

  // GETSTATUS answer, bState at index 4
  localparam usb_dfu_pkg::byte_t status_model [6] = '{
    usb_dfu_pkg::dfu_status_ok, 8'h00, 8'h00, 8'h00, usb_dfu_pkg::dfu_state_idle, 8'h00
  };

  logic               clk;
  logic               reset;
  logic               out_ep_req, out_ep_grant, out_ep_data_avail, out_ep_setup;
  logic               out_ep_data_get, out_ep_stall, out_ep_acked;
  usb_dfu_pkg::byte_t out_ep_data;
  logic               in_ep_req, in_ep_grant, in_ep_data_free, in_ep_data_put;
  logic               in_ep_data_done, in_ep_stall, in_ep_acked;
  usb_dfu_pkg::byte_t in_ep_data;
  logic [6:0]         dev_addr;

  usb_dfu_pkg::byte_t rx_bytes [$];
  usb_dfu_pkg::byte_t exp_bytes [$];
  int                 done_count, stall_count;
  int                 error_count, check_count, test_count, errors_at_start;
  logic               exp_stall, exp_in;
  logic [6:0]         model_addr, next_addr, new_addr;
  usb_dfu_pkg::word_t wlen;
  int                 sel;

  usb_dfu_ctrl_ep UUT (.*);

  always #4 clk = ~clk;

  // host side view of the IN endpoint
  always @(posedge clk) begin
    if (!reset) begin
      if (in_ep_grant && in_ep_data_put) rx_bytes.push_back(in_ep_data);
      if (in_ep_data_done) done_count = done_count + 1;
      if (in_ep_stall) stall_count = stall_count + 1;
      check_value("out_ep_req", out_ep_req, out_ep_data_avail);  // follows avail
      check_value("out_ep_data_get", out_ep_data_get, out_ep_data_avail);
      check_value("out_ep_stall", out_ep_stall, 1'b0);
    end
  end

  //////////////////////////////////////////////////
  // checking and reporting
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Error at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (error_count == errors_at_start) $display("test %0d %s: ok", test_count, name);
    else $display("test %0d %s: %0d errors", test_count, name, error_count - errors_at_start);
    errors_at_start = error_count;
  endtask

  task automatic abort_run(input string what);
    $display("timeout: %s", what);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  // expected answer straight from the request fields
  task automatic model_request(input usb_dfu_pkg::byte_t bm, input usb_dfu_pkg::byte_t breq,
                               input usb_dfu_pkg::word_t wvalue,
                               input usb_dfu_pkg::word_t wlength);
    int   start;
    int   len;
    logic from_status;
    start = 0;
    len = 0;
    from_status = 1'b0;
    exp_stall = 1'b0;
    next_addr = model_addr;
    case ({bm, breq})
      16'h8006: begin  // GET_DESCRIPTOR
        case (wvalue[15:8])
          8'h01: len = 18;
          8'h02: begin
            start = 18;
            len = 27;
          end
          8'h03: begin
            start = 45;
            len = 4;
            exp_stall = (wvalue[7:0] != 8'h00);  // language table only
          end
          default: exp_stall = 1'b1;
        endcase
      end
      16'h0005: next_addr = wvalue[6:0];
      16'h0009, 16'h2106: ;  // set config, abort
      16'ha103: begin
        from_status = 1'b1;
        len = 6;
      end
      16'ha105: begin
        from_status = 1'b1;
        start = 4;
        len = 1;
      end
      default: exp_stall = 1'b1;
    endcase
    if (exp_stall) len = 0;
    exp_in = (len != 0) && (wlength != 0);
    exp_bytes.delete();
    for (int i = 0; i < len && i < wlength; i++) begin
      exp_bytes.push_back(from_status ? status_model[start + i] : desc_model[start + i]);
    end
  endtask

  //////////////////////////////////////////////////
  // host model
  //////////////////////////////////////////////////

  // byte i of the packet sits at pkt[8*i +: 8]
  task automatic send_setup(input logic [63:0] pkt);
    @(negedge clk);
    out_ep_data_avail = 1'b1;
    out_ep_grant = 1'b1;
    out_ep_setup = 1'b1;
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      out_ep_data = pkt[8*i +: 8];  // valid the cycle after avail && grant
      if (i == 7) begin
        out_ep_data_avail = 1'b0;
        out_ep_grant = 1'b0;
      end
    end
    @(negedge clk);
    out_ep_setup = 1'b0;
    out_ep_data = 8'h00;
  endtask

  task automatic run_request(input usb_dfu_pkg::byte_t bm, input usb_dfu_pkg::byte_t breq,
                             input usb_dfu_pkg::word_t wvalue,
                             input usb_dfu_pkg::word_t wlength);
    int done_before;
    int stall_before;
    int cycles;
    model_request(bm, breq, wvalue, wlength);
    rx_bytes.delete();
    done_before = done_count;
    stall_before = stall_count;
    send_setup({wlength[15:8], wlength[7:0], 16'h0000, wvalue[15:8], wvalue[7:0], breq, bm});
    cycles = 0;
    while (done_count == done_before && stall_count == stall_before) begin
      @(negedge clk);
      check_value("in_ep_req", in_ep_req, rx_bytes.size() < exp_bytes.size());  // bytes left
      in_ep_grant = ($urandom % 4) != 0;  // random gaps on both strobes
      in_ep_data_free = ($urandom % 3) != 0;
      cycles++;
      if (cycles > wait_limit) abort_run("no in_ep_data_done or in_ep_stall after setup");
    end
    in_ep_grant = 1'b0;
    in_ep_data_free = 1'b0;
    check_value("dev_addr before status", dev_addr, model_addr);
    if (stall_count == stall_before) begin
      in_ep_acked = 1'b1;
      @(negedge clk);
      in_ep_acked = 1'b0;
      if (exp_in) begin  // status stage is an OUT zlp
        out_ep_acked = 1'b1;
        @(negedge clk);
        out_ep_acked = 1'b0;
      end
    end
    model_addr = next_addr;
    check_value("dev_addr after status", dev_addr, model_addr);
    check_value("in_ep_stall pulses", stall_count - stall_before, exp_stall);
    check_value("in_ep_data_done pulses", done_count - done_before, !exp_stall);
    check_value("in byte count", rx_bytes.size(), exp_bytes.size());
    for (int i = 0; i < rx_bytes.size() && i < exp_bytes.size(); i++) begin
      check_value($sformatf("in_ep_data[%0d]", i), rx_bytes[i], exp_bytes[i]);
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h8e9e_55c8));
    {done_count, stall_count, error_count, check_count, test_count, errors_at_start} = '0;
    model_addr = 7'd0;
    clk = 1'b0;
    reset = 1'b1;
    out_ep_grant = 1'b0;
    out_ep_data_avail = 1'b0;
    out_ep_setup = 1'b0;
    out_ep_data = 8'h00;
    out_ep_acked = 1'b0;
    in_ep_grant = 1'b0;
    in_ep_data_free = 1'b0;
    in_ep_acked = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    run_request(8'h80, 8'h06, {usb_dfu_pkg::DEVICE, 8'h00}, 16'd1 + 16'($urandom % 40));
    end_test("device descriptor");

    run_request(8'h80, 8'h06, {usb_dfu_pkg::CONFIGURATION, 8'h00}, 16'd1 + 16'($urandom % 64));
    run_request(8'h80, 8'h06, {usb_dfu_pkg::STRING, 8'h00}, 16'd1 + 16'($urandom % 8));
    end_test("configuration and language string");

    run_request(8'h80, 8'h06, {usb_dfu_pkg::DEVICE_QUALIFIER, 8'h00}, 16'd10);
    run_request(8'h80, 8'h06, {usb_dfu_pkg::STRING, 8'h01}, 16'd255);
    run_request(8'h80, 8'h06, {usb_dfu_pkg::DEVICE, 8'h00}, 16'd18);
    end_test("stalled descriptors");

    new_addr = 7'(1 + $urandom % 127);
    run_request(8'h00, 8'h05, {9'h000, new_addr}, 16'd0);
    check_value("dev_addr", dev_addr, new_addr);
    run_request(8'h00, 8'h09, 16'h0001, 16'd0);
    end_test("set address and configuration");

    run_request(8'ha1, 8'h03, 16'h0000, 16'd6);
    run_request(8'ha1, 8'h05, 16'h0000, 16'd1);
    end_test("dfu status and state");

    run_request(8'h21, 8'h06, 16'h0000, 16'd0);
    run_request(8'ha1, 8'h05, 16'h0000, 16'd1);
    end_test("dfu abort");

    for (int n = 0; n < 12; n++) begin
      sel = $urandom % 5;
      wlen = 16'd1 + 16'($urandom % 64);
      case (sel)
        0: run_request(8'h80, 8'h06, 16'h0100, wlen);
        1: run_request(8'h80, 8'h06, 16'h0200, wlen);
        2: run_request(8'h80, 8'h06, 16'h0300, wlen);
        3: run_request(8'ha1, 8'h03, 16'h0000, wlen);
        default: run_request(8'ha1, 8'h05, 16'h0000, wlen);
      endcase
    end
    end_test("random request mix");

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- usb_ctrl_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module usb_ctrl_sequencer (
  input  logic         clk,
  input  logic         reset,
  input  logic         out_ep_data_avail,
  input  logic         out_ep_setup,
  input  logic         out_ep_acked,
  input  logic         in_ep_acked,
  input  logic         all_sent,
  ctrl_req_if.consumer req,
  output logic         setup_end,
  output logic         data_in_phase,
  output logic         status_end,
  output logic         in_ep_data_done,
  output logic         in_ep_stall,
  output logic [6:0]   dev_addr
);

  usb_dfu_pkg::xfr_state_e state;
  usb_dfu_pkg::xfr_state_e state_next;

  logic       avail_q;
  logic       all_sent_q;
  logic       pkt_start;
  logic       pkt_end;
  logic       send_zlp;
  logic       sent_done;      // registered rise of all_sent
  logic       addr_pending;
  logic [6:0] addr_pending_val;

  assign pkt_start = out_ep_data_avail && !avail_q;
  assign pkt_end = !out_ep_data_avail && avail_q;

  assign data_in_phase = (state == usb_dfu_pkg::DATA_IN);
  assign in_ep_data_done = sent_done || send_zlp;

  //////////////////////////////////////////////////
  // control transfer stages
  //////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    setup_end = 1'b0;
    status_end = 1'b0;
    send_zlp = 1'b0;
    in_ep_stall = 1'b0;
    case (state)
      usb_dfu_pkg::IDLE: begin
        if (pkt_start && out_ep_setup) state_next = usb_dfu_pkg::SETUP_IN;
      end
      usb_dfu_pkg::SETUP_IN: begin
        if (pkt_end) state_next = usb_dfu_pkg::SETUP_DONE;
      end
      usb_dfu_pkg::SETUP_DONE: begin
        setup_end = 1'b1;
        if (req.stall_req) begin
          in_ep_stall = 1'b1;   // abort, back to idle
          status_end = 1'b1;
          state_next = usb_dfu_pkg::IDLE;
        end else if (req.has_data && req.dir_in) begin
          state_next = usb_dfu_pkg::DATA_IN;
        end else if (req.has_data) begin
          state_next = usb_dfu_pkg::DATA_OUT;
        end else begin
          send_zlp = 1'b1;      // no data stage
          state_next = usb_dfu_pkg::STATUS_IN;
        end
      end
      usb_dfu_pkg::DATA_IN: begin
        if (in_ep_acked && all_sent) state_next = usb_dfu_pkg::STATUS_OUT;
      end
      usb_dfu_pkg::DATA_OUT: begin
        if (out_ep_acked) begin
          send_zlp = 1'b1;
          state_next = usb_dfu_pkg::STATUS_IN;
        end
      end
      usb_dfu_pkg::STATUS_IN: begin
        if (in_ep_acked) begin
          status_end = 1'b1;
          state_next = usb_dfu_pkg::IDLE;
        end
      end
      usb_dfu_pkg::STATUS_OUT: begin
        if (out_ep_acked) begin
          status_end = 1'b1;
          state_next = usb_dfu_pkg::IDLE;
        end
      end
      default: state_next = usb_dfu_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= usb_dfu_pkg::IDLE;
      avail_q <= 1'b0;
      all_sent_q <= 1'b0;
      sent_done <= 1'b0;
    end else begin
      state <= state_next;
      avail_q <= out_ep_data_avail;
      all_sent_q <= all_sent;
      sent_done <= data_in_phase && all_sent && !all_sent_q;
    end
  end

  //////////////////////////////////////////////////
  // device address
  //////////////////////////////////////////////////

  // status token still uses the old address, so commit after it
  always_ff @(posedge clk) begin
    if (reset) begin
      addr_pending <= 1'b0;
      dev_addr <= '0;
    end else if (status_end) begin
      if (addr_pending && state == usb_dfu_pkg::STATUS_IN) dev_addr <= addr_pending_val;
      addr_pending <= 1'b0;
    end else if (setup_end && req.set_addr) begin
      addr_pending <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (setup_end && req.set_addr) addr_pending_val <= req.new_addr;
  end

endmodule

`default_nettype wire

//--- usb_desc_source.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_dfu_settings.svh"

module usb_desc_source (
  input  logic               clk,
  input  logic               reset,
  input  logic               setup_end,
  input  logic               data_in_phase,
  input  logic               status_end,
  input  logic               in_ep_grant,
  input  logic               in_ep_data_free,
  ctrl_req_if.consumer       req,
  output logic               in_ep_req,
  output logic               in_ep_data_put,
  output usb_dfu_pkg::byte_t in_ep_data,
  output logic               all_sent
);

  localparam usb_dfu_pkg::word_t vid = `USB_VENDOR_ID;
  localparam usb_dfu_pkg::word_t pid = `USB_PRODUCT_ID;
  localparam usb_dfu_pkg::word_t xfer_size = `DFU_TRANSFER_SIZE;

  //////////////////////////////////////////////////
  // descriptor tables
  //////////////////////////////////////////////////

  localparam usb_dfu_pkg::byte_t dev_desc [18] = '{
    8'd18, 8'h01, 8'h00, 8'h01, 8'h00, 8'h00, 8'h00, `USB_MAX_PACKET_SIZE,
    vid[7:0], vid[15:8], pid[7:0], pid[15:8],
    8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h01   // no strings, one config
  };

  localparam usb_dfu_pkg::byte_t cfg_desc [27] = '{
    8'd9, 8'h02, 8'd27, 8'h00, 8'h01, 8'h01, 8'h00, 8'hc0, 8'd50,  // configuration
    8'd9, 8'h04, 8'h00, 8'h00, 8'h00, 8'hfe, 8'h01, 8'h02, 8'h00,  // dfu interface
    8'd9, 8'h21, 8'h0b, 8'hff, 8'h00,                              // dfu functional
    xfer_size[7:0], xfer_size[15:8], 8'h1a, 8'h01
  };

  localparam usb_dfu_pkg::byte_t lang_desc [4] = '{8'd4, 8'h03, 8'h09, 8'h04};  // en-US

  // bStatus, bwPollTimeout[3], bState, iString
  localparam usb_dfu_pkg::byte_t status_rom [6] = '{
    usb_dfu_pkg::dfu_status_ok, 8'h00, 8'h00, 8'h00, usb_dfu_pkg::dfu_state_idle, 8'h00
  };

  localparam int lang_offset = usb_dfu_pkg::desc_cfg_offset + $size(cfg_desc);

  typedef usb_dfu_pkg::byte_t rom_t [`DESC_ROM_DEPTH];

  function automatic rom_t build_desc_rom();
    rom_t rom;
    rom = '{default: 8'h00};
    foreach (dev_desc[i]) rom[i] = dev_desc[i];
    foreach (cfg_desc[i]) rom[usb_dfu_pkg::desc_cfg_offset + i] = cfg_desc[i];
    foreach (lang_desc[i]) rom[lang_offset + i] = lang_desc[i];
    return rom;
  endfunction

  localparam rom_t desc_rom = build_desc_rom();

  logic [`DESC_ADDR_WIDTH-1:0] rd_addr;
  usb_dfu_pkg::word_t          src_left;    // bytes left in the answer
  usb_dfu_pkg::word_t          host_left;   // bytes left of wLength
  usb_dfu_pkg::data_src_e      src_q;

  //////////////////////////////////////////////////
  // counters and IN data path
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || status_end) begin
      rd_addr <= '0;
      src_left <= '0;
      host_left <= '0;
      src_q <= usb_dfu_pkg::DESC_TABLE;
    end else if (setup_end) begin
      rd_addr <= req.src_addr;
      src_left <= req.src_len;
      host_left <= req.wlength;
      src_q <= req.src;
    end else if (in_ep_grant && in_ep_data_put) begin  // byte taken
      rd_addr <= rd_addr + 1'b1;
      src_left <= src_left - 16'd1;
      host_left <= host_left - 16'd1;
    end
  end

  assign all_sent = (src_left == '0) || (host_left == '0);
  assign in_ep_req = data_in_phase && !all_sent;
  assign in_ep_data_put = in_ep_req && in_ep_data_free;

  always_comb begin
    if (src_q == usb_dfu_pkg::STATUS_TABLE) begin
      in_ep_data = (rd_addr < 6) ? status_rom[rd_addr[2:0]] : 8'h00;
    end else begin
      in_ep_data = desc_rom[rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- usb_dfu_ctrl_ep.sv
`timescale 1ns/1ps
`default_nettype none

module usb_dfu_ctrl_ep (
  input  logic               clk,
  input  logic               reset,
  // out endpoint
  output logic               out_ep_req,
  input  logic               out_ep_grant,
  input  logic               out_ep_data_avail,
  input  logic               out_ep_setup,
  output logic               out_ep_data_get,
  input  usb_dfu_pkg::byte_t out_ep_data,
  output logic               out_ep_stall,
  input  logic               out_ep_acked,
  // in endpoint
  output logic               in_ep_req,
  input  logic               in_ep_grant,
  input  logic               in_ep_data_free,
  output logic               in_ep_data_put,
  output usb_dfu_pkg::byte_t in_ep_data,
  output logic               in_ep_data_done,
  output logic               in_ep_stall,
  input  logic               in_ep_acked,
  output logic [6:0]         dev_addr
);

  logic setup_end;
  logic data_in_phase;
  logic status_end;
  logic all_sent;

  ctrl_req_if req_if ();

  assign out_ep_req = out_ep_data_avail;       // take every byte offered
  assign out_ep_data_get = out_ep_data_avail;
  assign out_ep_stall = 1'b0;                  // no OUT data requests

  usb_setup_decoder u_decoder (
    .clk              (clk),
    .reset            (reset),
    .out_ep_data_avail(out_ep_data_avail),
    .out_ep_grant     (out_ep_grant),
    .out_ep_setup     (out_ep_setup),
    .out_ep_data      (out_ep_data),
    .status_end       (status_end),
    .req              (req_if.decoder)
  );

  usb_ctrl_sequencer u_sequencer (
    .clk              (clk),
    .reset            (reset),
    .out_ep_data_avail(out_ep_data_avail),
    .out_ep_setup     (out_ep_setup),
    .out_ep_acked     (out_ep_acked),
    .in_ep_acked      (in_ep_acked),
    .all_sent         (all_sent),
    .req              (req_if.consumer),
    .setup_end        (setup_end),
    .data_in_phase    (data_in_phase),
    .status_end       (status_end),
    .in_ep_data_done  (in_ep_data_done),
    .in_ep_stall      (in_ep_stall),
    .dev_addr         (dev_addr)
  );

  usb_desc_source u_source (
    .clk            (clk),
    .reset          (reset),
    .setup_end      (setup_end),
    .data_in_phase  (data_in_phase),
    .status_end     (status_end),
    .in_ep_grant    (in_ep_grant),
    .in_ep_data_free(in_ep_data_free),
    .req            (req_if.consumer),
    .in_ep_req      (in_ep_req),
    .in_ep_data_put (in_ep_data_put),
    .in_ep_data     (in_ep_data),
    .all_sent       (all_sent)
  );

endmodule

`default_nettype wire

//--- usb_dfu_pkg.sv
`default_nettype none

package usb_dfu_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [15:0] word_t;

  // control transfer stages
  typedef enum logic [2:0] {
    IDLE,
    SETUP_IN,
    SETUP_DONE,
    DATA_IN,
    DATA_OUT,
    STATUS_IN,
    STATUS_OUT
  } xfr_state_e;

  // {bmRequestType[6:5], bRequest}
  typedef enum logic [9:0] {
    SET_ADDRESS       = 10'h005,
    GET_DESCRIPTOR    = 10'h006,
    SET_CONFIGURATION = 10'h009,
    DFU_GETSTATUS     = 10'h103,  // class requests
    DFU_GETSTATE      = 10'h105,
    DFU_ABORT         = 10'h106
  } request_e;

  // high byte of wValue for GET_DESCRIPTOR
  typedef enum logic [7:0] {
    DEVICE           = 8'h01,
    CONFIGURATION    = 8'h02,
    STRING           = 8'h03,
    DEVICE_QUALIFIER = 8'h06
  } desc_type_e;

  typedef enum logic {
    DESC_TABLE,
    STATUS_TABLE
  } data_src_e;

  localparam byte_t dfu_state_idle = 8'h02;   // dfuIDLE
  localparam byte_t dfu_status_ok = 8'h00;    // OK
  localparam byte_t desc_cfg_offset = 8'd18;  // config set follows device desc

endpackage

`default_nettype wire

//--- usb_dfu_settings.svh
`ifndef USB_DFU_SETTINGS_SVH
`define USB_DFU_SETTINGS_SVH

//////////////////////////////////////////////////
// endpoint 0 packet sizes
//////////////////////////////////////////////////

// bMaxPacketSize0, full speed control endpoint
`define USB_MAX_PACKET_SIZE 8'd32

// wTransferSize advertised in the DFU functional descriptor
`define DFU_TRANSFER_SIZE 16'd4096

//////////////////////////////////////////////////
// device identity
//////////////////////////////////////////////////

`define USB_VENDOR_ID  16'h1d50  // idVendor
`define USB_PRODUCT_ID 16'h6130  // idProduct

//////////////////////////////////////////////////
// descriptor table geometry
//////////////////////////////////////////////////

// device + configuration set + language string fit in 64 bytes
`define DESC_ROM_DEPTH  64
`define DESC_ADDR_WIDTH 6

`endif

//--- usb_setup_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_dfu_settings.svh"

module usb_setup_decoder (
  input  logic               clk,
  input  logic               reset,
  input  logic               out_ep_data_avail,
  input  logic               out_ep_grant,
  input  logic               out_ep_setup,
  input  usb_dfu_pkg::byte_t out_ep_data,
  input  logic               status_end,
  ctrl_req_if.decoder        req
);

  localparam int aw = `DESC_ADDR_WIDTH;

  // answer lengths, must agree with the tables in usb_desc_source
  localparam usb_dfu_pkg::word_t dev_len = 16'd18;
  localparam usb_dfu_pkg::word_t cfg_len = 16'd27;   // config + interface + dfu func
  localparam usb_dfu_pkg::word_t lang_len = 16'd4;
  localparam usb_dfu_pkg::word_t stat_len = 16'd6;
  localparam int lang_offset = usb_dfu_pkg::desc_cfg_offset + cfg_len;
  localparam int state_offset = 4;                    // bState inside status table

  logic               out_ep_data_valid;
  logic [2:0]         setup_ptr;
  usb_dfu_pkg::byte_t setup_mem [8];
  usb_dfu_pkg::byte_t bm_request_type;
  usb_dfu_pkg::byte_t b_request;
  usb_dfu_pkg::word_t w_value;
  logic [9:0]         req_code;

  //////////////////////////////////////////////////
  // setup packet capture
  //////////////////////////////////////////////////

  // byte shows up the cycle after avail && grant
  always_ff @(posedge clk) begin
    if (reset) begin
      out_ep_data_valid <= 1'b0;
    end else begin
      out_ep_data_valid <= out_ep_data_avail && out_ep_grant;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || status_end) begin
      setup_ptr <= '0;
    end else if (out_ep_setup && out_ep_data_valid) begin
      setup_ptr <= setup_ptr + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_ep_setup && out_ep_data_valid) begin
      setup_mem[setup_ptr] <= out_ep_data;
    end
  end

  //////////////////////////////////////////////////
  // request decode
  //////////////////////////////////////////////////

  assign bm_request_type = setup_mem[0];
  assign b_request = setup_mem[1];
  assign w_value = {setup_mem[3], setup_mem[2]};
  assign req_code = {bm_request_type[6:5], b_request};  // type bits + bRequest

  assign req.dir_in = bm_request_type[7];
  assign req.wlength = {setup_mem[7], setup_mem[6]};
  assign req.has_data = |req.wlength;
  assign req.new_addr = w_value[6:0];

  always_comb begin
    req.src = usb_dfu_pkg::DESC_TABLE;
    req.src_addr = '0;
    req.src_len = '0;
    req.stall_req = 1'b0;
    req.set_addr = 1'b0;
    case (req_code)
      usb_dfu_pkg::GET_DESCRIPTOR: begin
        case (w_value[15:8])
          usb_dfu_pkg::DEVICE: req.src_len = dev_len;
          usb_dfu_pkg::CONFIGURATION: begin
            req.src_addr = aw'(usb_dfu_pkg::desc_cfg_offset);
            req.src_len = cfg_len;
          end
          usb_dfu_pkg::STRING: begin
            if (w_value[7:0] == 8'h00) begin  // only the language table
              req.src_addr = aw'(lang_offset);
              req.src_len = lang_len;
            end else begin
              req.stall_req = 1'b1;
            end
          end
          default: req.stall_req = 1'b1;  // device qualifier too, full speed only
        endcase
      end
      usb_dfu_pkg::SET_ADDRESS: req.set_addr = 1'b1;
      usb_dfu_pkg::SET_CONFIGURATION: ;  // single config, nothing to hold
      usb_dfu_pkg::DFU_GETSTATUS: begin
        req.src = usb_dfu_pkg::STATUS_TABLE;
        req.src_len = stat_len;
      end
      usb_dfu_pkg::DFU_GETSTATE: begin
        req.src = usb_dfu_pkg::STATUS_TABLE;
        req.src_addr = aw'(state_offset);
        req.src_len = 16'd1;
      end
      usb_dfu_pkg::DFU_ABORT: ;  // already dfuIDLE
      default: req.stall_req = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
usb_dfu_pkg.sv
ctrl_req_if.sv
usb_setup_decoder.sv
usb_ctrl_sequencer.sv
usb_desc_source.sv
usb_dfu_ctrl_ep.sv
tb_usb_dfu_ctrl_ep.sv
